// File: src/hdmi_tx_consts.svh
`ifndef HDMI_TX_CONSTS_SVH
`define HDMI_TX_CONSTS_SVH

// 7-bit bus address of the ADV7513 main register map
`define ADV7513_I2C_ADDR 7'h39

// status register read back after the write sequence
`define ADV7513_PLL_REG 8'h9E

// PLL lock flag position inside the status register
`define ADV7513_PLL_LOCK_BIT 4

// number of register writes in the init table
`define INIT_SEQ_LEN 27

// clock cycles per quarter of an SCL period
// one SCL period is four of these quarters,
// so the bus runs at clk / (4 * divider)
`define I2C_QUARTER_DIV 4

// with the default of 4 and a 50 MHz clock
// this gives a very fast bus, which suits simulation;
// a board build would raise it to reach 100 kHz or 400 kHz
//
// the divider counter is sized from this value,
// so any value of 1 or more is legal

`endif

// File: src/hdmi_tx_pkg.sv
package hdmi_tx_pkg;

    // device register address and value
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // position in the init write table
    typedef logic [4:0] seq_index_t;

    // failed PLL checks, wraps at 255
    typedef logic [7:0] err_count_t;

    // one table entry
    typedef struct packed {
        reg_addr_t reg_addr;
        reg_data_t value;
    } reg_write_t;

    // request to the I2C master, value ignored on reads
    typedef struct packed {
        logic      is_read;
        reg_addr_t reg_addr;
        reg_data_t value;
    } i2c_cmd_t;

    // answer from the I2C master, data only meaningful on reads
    typedef struct packed {
        logic      ack_error;
        reg_data_t data;
    } i2c_rsp_t;

    typedef enum logic [2:0] {
        CFG_WRITE, CFG_WRITE_WAIT, CFG_READ, CFG_READ_WAIT, CFG_READY
    } config_state_t;

    typedef enum logic [2:0] {I2C_IDLE, I2C_START, I2C_TX, I2C_RX, I2C_STOP} i2c_state_t;

endpackage

// File: src/adv7513_init_rom.sv
`timescale 1ns/1ps

module adv7513_init_rom #(
    parameter bit aspect_16_9 = 1'b0
) (
    input  hdmi_tx_pkg::seq_index_t index,
    output hdmi_tx_pkg::reg_write_t entry
);

    // register 0x17 bit 1 selects the input aspect ratio
    localparam hdmi_tx_pkg::reg_data_t aspect_value = aspect_16_9 ? 8'h02 : 8'h00;

    always_comb begin
        case (index)
            // all circuits powered up, sync adjust off
            5'd0:  entry = 16'h41_10;
            // fixed values the handbook asks for
            5'd1:  entry = 16'h98_03;
            5'd2:  entry = 16'h9A_E0;
            5'd3:  entry = 16'h9C_30;
            5'd4:  entry = 16'h9D_01;
            5'd5:  entry = 16'hA2_A4;
            5'd6:  entry = 16'hA3_A4;
            5'd7:  entry = 16'hE0_D0;
            5'd8:  entry = 16'hF9_00;
            // 44.1 kHz I2S, 24 bit RGB 4:4:4 with separate syncs
            5'd9:  entry = 16'h15_00;
            5'd10: entry = {8'h17, aspect_value};
            // 4:4:4 out, 8 bit colour depth
            5'd11: entry = 16'h16_30;
            // RGB in the AVI InfoFrame, CSC off
            5'd12: entry = 16'h55_00;
            5'd13: entry = 16'h18_46;
            // HDMI mode, HDCP off
            5'd14: entry = 16'hAF_06;
            5'd15: entry = 16'hBA_60;
            // I2S audio with automatic CTS
            5'd16: entry = 16'h0A_00;
            // N = 0x1880 for 44.1 kHz
            5'd17: entry = 16'h01_00;
            5'd18: entry = 16'h02_18;
            5'd19: entry = 16'h03_80;
            5'd20: entry = 16'h0B_0E;
            // I2S0 on, right justified, 16 bit samples
            5'd21: entry = 16'h0C_05;
            5'd22: entry = 16'h0D_10;
            // HPD and monitor sense interrupts on, then clear pending ones
            5'd23: entry = 16'h94_C0;
            5'd24: entry = 16'h96_C0;
            // no pixel repetition, VIC left automatic
            5'd25: entry = 16'h3B_80;
            5'd26: entry = 16'h3C_00;
            default: entry = '0;
        endcase
    end

endmodule

// File: src/i2c_master.sv
`timescale 1ns/1ps
`include "hdmi_tx_consts.svh"

module i2c_master (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  hdmi_tx_pkg::i2c_cmd_t cmd,
    output logic                  rsp_valid,
    output hdmi_tx_pkg::i2c_rsp_t rsp,
    input  logic                  scl_in,
    input  logic                  sda_in,
    output logic                  scl_oe,
    output logic                  sda_oe
);

    localparam int div_w = $clog2(`I2C_QUARTER_DIV + 1);

    hdmi_tx_pkg::i2c_state_t state;
    hdmi_tx_pkg::i2c_cmd_t   cmd_q;
    logic [div_w-1:0]        div_cnt;
    logic [1:0]              phase;
    logic [3:0]              bit_cnt;
    logic [1:0]              byte_sel;
    logic [7:0]              shift;
    logic                    ack_err;
    logic                    stall;
    logic                    tick;

    // slave still holds SCL low after we let it go
    assign stall = (state != hdmi_tx_pkg::I2C_IDLE) && !scl_oe && !scl_in;
    assign tick  = !stall && (div_cnt == div_w'(`I2C_QUARTER_DIV - 1));

    // every bit takes four quarters:
    // 0 set SDA, 1 release SCL, 2 sample SDA, 3 pull SCL low
    always_ff @(posedge clk) begin
        rsp_valid <= 1'b0;
        if (!reset) begin
            state    <= hdmi_tx_pkg::I2C_IDLE;
            div_cnt  <= '0;
            phase    <= '0;
            bit_cnt  <= '0;
            byte_sel <= '0;
            ack_err  <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else if (state == hdmi_tx_pkg::I2C_IDLE) begin
            if (cmd_valid) begin
                cmd_q    <= cmd;
                shift    <= {`ADV7513_I2C_ADDR, 1'b0};
                div_cnt  <= '0;
                phase    <= '0;
                bit_cnt  <= '0;
                byte_sel <= '0;
                ack_err  <= 1'b0;
                state    <= hdmi_tx_pkg::I2C_START;
            end
        end else if (!tick) begin
            if (!stall) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end else begin
            div_cnt <= '0;
            phase   <= phase + 1'b1;
            case (state)
                // also used as repeated start, SCL may be low on entry
                hdmi_tx_pkg::I2C_START: begin
                    case (phase)
                        2'd0: sda_oe <= 1'b0;
                        2'd1: scl_oe <= 1'b0;
                        2'd2: sda_oe <= 1'b1;
                        default: begin
                            scl_oe  <= 1'b1;
                            bit_cnt <= '0;
                            state   <= hdmi_tx_pkg::I2C_TX;
                        end
                    endcase
                end
                hdmi_tx_pkg::I2C_TX: begin
                    case (phase)
                        // ninth bit releases SDA for the slave ACK
                        2'd0: sda_oe <= (bit_cnt < 4'd8) && !shift[7];
                        2'd1: scl_oe <= 1'b0;
                        2'd2: begin
                            if (bit_cnt == 4'd8) begin
                                ack_err <= ack_err | sda_in;
                            end
                        end
                        default: begin
                            scl_oe  <= 1'b1;
                            shift   <= {shift[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd8) begin
                                bit_cnt <= '0;
                                case (byte_sel)
                                    2'd0: begin
                                        shift    <= cmd_q.reg_addr;
                                        byte_sel <= 2'd1;
                                    end
                                    2'd1: begin
                                        byte_sel <= 2'd2;
                                        if (cmd_q.is_read) begin
                                            shift <= {`ADV7513_I2C_ADDR, 1'b1};
                                            state <= hdmi_tx_pkg::I2C_START;
                                        end else begin
                                            shift <= cmd_q.value;
                                        end
                                    end
                                    default: begin
                                        state <= cmd_q.is_read ? hdmi_tx_pkg::I2C_RX
                                                               : hdmi_tx_pkg::I2C_STOP;
                                    end
                                endcase
                            end
                        end
                    endcase
                end
                // SDA stays released, so the ninth bit is the NACK
                hdmi_tx_pkg::I2C_RX: begin
                    case (phase)
                        2'd0: sda_oe <= 1'b0;
                        2'd1: scl_oe <= 1'b0;
                        2'd2: begin
                            if (bit_cnt < 4'd8) begin
                                shift <= {shift[6:0], sda_in};
                            end
                        end
                        default: begin
                            scl_oe  <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd8) begin
                                state <= hdmi_tx_pkg::I2C_STOP;
                            end
                        end
                    endcase
                end
                default: begin
                    case (phase)
                        2'd0: sda_oe <= 1'b1;
                        2'd1: scl_oe <= 1'b0;
                        // SDA rising while SCL is high
                        2'd2: sda_oe <= 1'b0;
                        default: begin
                            rsp.ack_error <= ack_err;
                            rsp.data      <= shift;
                            rsp_valid     <= 1'b1;
                            state         <= hdmi_tx_pkg::I2C_IDLE;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

// File: src/adv7513_config_fsm.sv
`timescale 1ns/1ps
`include "hdmi_tx_consts.svh"

module adv7513_config_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdmi_int,
    output hdmi_tx_pkg::seq_index_t seq_index,
    input  hdmi_tx_pkg::reg_write_t entry,
    output logic                    cmd_valid,
    output hdmi_tx_pkg::i2c_cmd_t   cmd,
    input  logic                    rsp_valid,
    input  hdmi_tx_pkg::i2c_rsp_t   rsp,
    output logic                    ready,
    output hdmi_tx_pkg::err_count_t pll_error_count
);

    localparam hdmi_tx_pkg::seq_index_t last_index =
        hdmi_tx_pkg::seq_index_t'(`INIT_SEQ_LEN - 1);

    hdmi_tx_pkg::config_state_t state;
    logic                       reading;
    logic                       pll_locked;

    assign reading = (state == hdmi_tx_pkg::CFG_READ) ||
                     (state == hdmi_tx_pkg::CFG_READ_WAIT);

    // command follows the table entry, or the status read during the PLL check
    assign cmd.is_read  = reading;
    assign cmd.reg_addr = reading ? `ADV7513_PLL_REG : entry.reg_addr;
    assign cmd.value    = reading ? '0 : entry.value;

    assign pll_locked = rsp.data[`ADV7513_PLL_LOCK_BIT];

    always_ff @(posedge clk) begin
        cmd_valid <= 1'b0;
        if (!reset) begin
            state           <= hdmi_tx_pkg::CFG_WRITE;
            seq_index       <= '0;
            ready           <= 1'b0;
            pll_error_count <= '0;
        end else begin
            case (state)
                hdmi_tx_pkg::CFG_WRITE: begin
                    cmd_valid <= 1'b1;
                    state     <= hdmi_tx_pkg::CFG_WRITE_WAIT;
                end
                hdmi_tx_pkg::CFG_WRITE_WAIT: begin
                    if (rsp_valid) begin
                        if (rsp.ack_error) begin
                            // same entry again
                            state <= hdmi_tx_pkg::CFG_WRITE;
                        end else if (seq_index == last_index) begin
                            state <= hdmi_tx_pkg::CFG_READ;
                        end else begin
                            seq_index <= seq_index + 1'b1;
                            state     <= hdmi_tx_pkg::CFG_WRITE;
                        end
                    end
                end
                hdmi_tx_pkg::CFG_READ: begin
                    cmd_valid <= 1'b1;
                    state     <= hdmi_tx_pkg::CFG_READ_WAIT;
                end
                hdmi_tx_pkg::CFG_READ_WAIT: begin
                    if (rsp_valid) begin
                        if (rsp.ack_error) begin
                            state <= hdmi_tx_pkg::CFG_READ;
                        end else if (pll_locked) begin
                            ready <= 1'b1;
                            state <= hdmi_tx_pkg::CFG_READY;
                        end else begin
                            // PLL not locked yet, program the whole table again
                            pll_error_count <= pll_error_count + 1'b1;
                            seq_index       <= '0;
                            state           <= hdmi_tx_pkg::CFG_WRITE;
                        end
                    end
                end
                hdmi_tx_pkg::CFG_READY: begin
                    // hot plug or monitor sense event, the device may have
                    // dropped its settings
                    if (!hdmi_int) begin
                        ready     <= 1'b0;
                        seq_index <= '0;
                        state     <= hdmi_tx_pkg::CFG_WRITE;
                    end
                end
                default: begin
                    seq_index <= '0;
                    state     <= hdmi_tx_pkg::CFG_WRITE;
                end
            endcase
        end
    end

endmodule

// File: src/adv7513_ctrl.sv
`timescale 1ns/1ps

module adv7513_ctrl #(
    parameter bit aspect_16_9 = 1'b0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdmi_int,
    input  logic                    scl_in,
    input  logic                    sda_in,
    output logic                    scl_oe,
    output logic                    sda_oe,
    output logic                    ready,
    output hdmi_tx_pkg::err_count_t pll_error_count
);

    hdmi_tx_pkg::seq_index_t seq_index;
    hdmi_tx_pkg::reg_write_t entry;
    hdmi_tx_pkg::i2c_cmd_t   cmd;
    hdmi_tx_pkg::i2c_rsp_t   rsp;
    logic                    cmd_valid;
    logic                    rsp_valid;

    adv7513_init_rom #(
        .aspect_16_9 (aspect_16_9)
    ) u_rom (
        .index (seq_index),
        .entry (entry)
    );

    adv7513_config_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .seq_index       (seq_index),
        .entry           (entry),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

    i2c_master u_i2c (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe)
    );

endmodule

// File: tb/adv7513_i2c_model.sv
`timescale 1ns/1ps
`include "hdmi_tx_consts.svh"

module adv7513_i2c_model (
    input  logic clk,
    input  logic scl,
    input  logic sda,
    output logic scl_oe,
    output logic sda_oe,
    input  logic log_clear,
    input  int   pll_fail_reads,
    input  int   nack_at,
    input  logic stretch_en
);

    typedef enum logic [1:0] {BUS_IDLE, BUS_RECV, BUS_SEND} bus_mode_t;

    bus_mode_t               mode = BUS_IDLE;
    hdmi_tx_pkg::reg_data_t  regs [0:255];
    hdmi_tx_pkg::reg_write_t write_log [0:127];
    int                      write_count = 0;
    int                      pll_reads = 0;
    int                      stretch_left = 0;
    integer                  seed = 96;
    logic                    nack_done = 1'b0;
    logic                    scl_q = 1'b1;
    logic                    sda_q = 1'b1;
    logic                    is_read = 1'b0;
    logic [3:0]              bit_cnt = '0;
    logic [1:0]              byte_no = '0;
    logic [7:0]              shreg = '0;
    logic [7:0]              tx = '0;
    hdmi_tx_pkg::reg_addr_t  reg_ptr = '0;
    hdmi_tx_pkg::reg_data_t  rd_val;

    initial begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
        for (int i = 0; i < 256; i++) begin
            regs[i] = '0;
        end
    end

    // lines are sampled once per clock, bit_cnt counts SCL rises since start
    always @(posedge clk) begin
        scl_q <= scl;
        sda_q <= sda;
        if (stretch_left != 0) begin
            stretch_left <= stretch_left - 1;
            if (stretch_left == 1) begin
                scl_oe <= 1'b0;
            end
        end
        if (log_clear) begin
            write_count  <= 0;
            pll_reads    <= 0;
            nack_done    <= 1'b0;
            mode         <= BUS_IDLE;
            stretch_left <= 0;
            scl_oe       <= 1'b0;
            sda_oe       <= 1'b0;
        end else if (scl && scl_q && sda_q && !sda) begin
            // start or repeated start
            mode    <= BUS_RECV;
            bit_cnt <= '0;
            byte_no <= '0;
        end else if (scl && scl_q && !sda_q && sda) begin
            mode   <= BUS_IDLE;
            sda_oe <= 1'b0;
        end else if (mode != BUS_IDLE && !scl_q && scl) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (mode == BUS_RECV && bit_cnt < 4'd8) begin
                shreg <= {shreg[6:0], sda};
            end
        end else if (mode != BUS_IDLE && scl_q && !scl) begin
            if (stretch_en) begin
                scl_oe       <= 1'b1;
                stretch_left <= 6 + ({$random(seed)} % 24);
            end
            if (mode == BUS_RECV && bit_cnt == 4'd8) begin
                if (byte_no != 2'd3) begin
                    byte_no <= byte_no + 1'b1;
                end
                case (byte_no)
                    2'd0: begin
                        is_read <= shreg[0];
                        if (shreg[7:1] == `ADV7513_I2C_ADDR) begin
                            sda_oe <= 1'b1;
                        end else begin
                            mode <= BUS_IDLE;
                        end
                    end
                    2'd1: begin
                        reg_ptr <= shreg;
                        sda_oe  <= 1'b1;
                    end
                    default: begin
                        regs[reg_ptr] <= shreg;
                        if (write_count < 128) begin
                            write_log[write_count] <= {reg_ptr, shreg};
                        end
                        write_count <= write_count + 1;
                        // the chosen write is logged but refused once
                        if (write_count == nack_at && !nack_done) begin
                            nack_done <= 1'b1;
                        end else begin
                            sda_oe <= 1'b1;
                        end
                    end
                endcase
            end else if (mode == BUS_RECV && bit_cnt == 4'd9) begin
                sda_oe  <= 1'b0;
                bit_cnt <= '0;
                if (is_read) begin
                    rd_val = regs[reg_ptr];
                    if (reg_ptr == `ADV7513_PLL_REG) begin
                        rd_val[`ADV7513_PLL_LOCK_BIT] = (pll_reads >= pll_fail_reads);
                        pll_reads <= pll_reads + 1;
                    end
                    mode   <= BUS_SEND;
                    tx     <= rd_val;
                    sda_oe <= !rd_val[7];
                end
            end else if (mode == BUS_SEND) begin
                if (bit_cnt == 4'd8) begin
                    sda_oe <= 1'b0;
                end else if (bit_cnt == 4'd9) begin
                    mode <= BUS_IDLE;
                end else if (bit_cnt != 4'd0) begin
                    tx     <= {tx[6:0], 1'b0};
                    sda_oe <= !tx[6];
                end
            end
        end
    end

endmodule

// File: tb/adv7513_ctrl_tb.sv
`timescale 1ns/1ps
`include "hdmi_tx_consts.svh"

module adv7513_ctrl_tb;

    localparam bit aspect_16_9 = 1'b1;
    localparam int num_tests = 5;
    // four sequence passes of 28 transactions with up to 40 bit periods each
    localparam int test_budget = 4 * 28 * 40 * `I2C_QUARTER_DIV * 4;

    // register sequence as the ADV7513 setup lists it, 16:9 aspect in 0x17
    localparam hdmi_tx_pkg::reg_write_t init_table [0:`INIT_SEQ_LEN-1] = '{
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4, 16'hA3A4,
        16'hE0D0, 16'hF900, 16'h1500, 16'h1702,
        16'h1630, 16'h5500, 16'h1846, 16'hAF06, 16'hBA60, 16'h0A00, 16'h0100,
        16'h0218, 16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h94C0, 16'h96C0,
        16'h3B80, 16'h3C00
    };

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    hdmi_int;
    logic                    dut_scl_oe;
    logic                    dut_sda_oe;
    logic                    model_scl_oe;
    logic                    model_sda_oe;
    logic                    scl_line;
    logic                    sda_line;
    logic                    ready;
    hdmi_tx_pkg::err_count_t pll_error_count;
    logic                    log_clear;
    int                      pll_fail_reads;
    int                      nack_at;
    logic                    stretch_en;
    int                      errors = 0;
    int                      passed = 0;
    int                      failed = 0;

    // open-drain bus where either side pulls the line low
    assign scl_line = !(dut_scl_oe || model_scl_oe);
    assign sda_line = !(dut_sda_oe || model_sda_oe);

    always #10 clk = !clk;

    adv7513_ctrl #(
        .aspect_16_9 (aspect_16_9)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .hdmi_int        (hdmi_int),
        .scl_in          (scl_line),
        .sda_in          (sda_line),
        .scl_oe          (dut_scl_oe),
        .sda_oe          (dut_sda_oe),
        .ready           (ready),
        .pll_error_count (pll_error_count)
    );

    adv7513_i2c_model u_model (
        .clk            (clk),
        .scl            (scl_line),
        .sda            (sda_line),
        .scl_oe         (model_scl_oe),
        .sda_oe         (model_sda_oe),
        .log_clear      (log_clear),
        .pll_fail_reads (pll_fail_reads),
        .nack_at        (nack_at),
        .stretch_en     (stretch_en)
    );

    task automatic check_reg_addr(input string what, input hdmi_tx_pkg::reg_addr_t got,
                                  input hdmi_tx_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s address %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg_data(input string what, input hdmi_tx_pkg::reg_data_t got,
                                  input hdmi_tx_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s value %02h, expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input hdmi_tx_pkg::err_count_t got,
                               input hdmi_tx_pkg::err_count_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // log holds the table passes times with the entry at doubled written twice
    task automatic check_log(input int passes, input int doubled);
        hdmi_tx_pkg::reg_write_t expected [$];
        int                      n;
        int                      p;
        int                      i;
        for (p = 0; p < passes; p++) begin
            for (i = 0; i < `INIT_SEQ_LEN; i++) begin
                expected.push_back(init_table[i]);
                if (i == doubled) begin
                    expected.push_back(init_table[i]);
                end
            end
        end
        check_count("write log length", hdmi_tx_pkg::err_count_t'(u_model.write_count),
                    hdmi_tx_pkg::err_count_t'(expected.size()));
        n = (u_model.write_count < expected.size()) ? u_model.write_count : expected.size();
        for (i = 0; i < n; i++) begin
            check_reg_addr($sformatf("write %0d", i), u_model.write_log[i].reg_addr,
                           expected[i].reg_addr);
            check_reg_data($sformatf("write %0d", i), u_model.write_log[i].value,
                           expected[i].value);
        end
    endtask

    task automatic restart_dut(input int fail_reads, input int nack_pos, input logic stretch);
        @(posedge clk);
        reset          <= 1'b0;
        hdmi_int       <= 1'b1;
        pll_fail_reads <= fail_reads;
        nack_at        <= nack_pos;
        stretch_en     <= stretch;
        log_clear      <= 1'b1;
        @(posedge clk);
        log_clear <= 1'b0;
        repeat (8) @(posedge clk);
        // all outputs sit at their idle values while reset is held
        @(negedge clk);
        check_flag("ready in reset", ready, 1'b0);
        check_flag("scl_oe in reset", dut_scl_oe, 1'b0);
        check_flag("sda_oe in reset", dut_sda_oe, 1'b0);
        check_count("pll_error_count in reset", pll_error_count, '0);
        @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic wait_ready(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < test_budget && !seen; n++) begin
            @(negedge clk);
            seen = ready;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%s: passed", name);
            passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - start_errors);
            failed++;
        end
    endtask

    task automatic configure_and_check(input string name, input int fail_reads,
                                       input int nack_pos, input logic stretch);
        int   start_errors;
        logic seen;
        start_errors = errors;
        restart_dut(fail_reads, nack_pos, stretch);
        wait_ready(seen);
        if (!seen) begin
            $display("%s: ready did not rise within %0d cycles", name, test_budget);
            errors++;
        end else begin
            // ready has to hold once it is up
            repeat (4) @(negedge clk);
            check_log(fail_reads + 1, nack_pos);
            check_flag("ready", ready, 1'b1);
            check_count("pll_error_count", pll_error_count,
                        hdmi_tx_pkg::err_count_t'(fail_reads));
        end
        report_test(name, start_errors);
    endtask

    task automatic power_up_test();
        configure_and_check("power-up", 0, -1, 1'b0);
    endtask

    task automatic pll_retry_test();
        configure_and_check("pll retry", 2, -1, 1'b0);
    endtask

    task automatic nack_retry_test();
        configure_and_check("nack retry", 0, 9, 1'b0);
    endtask

    task automatic stretch_test();
        configure_and_check("clock stretch", 0, -1, 1'b1);
    endtask

    task automatic hot_plug_test();
        int   start_errors;
        logic seen;
        start_errors = errors;
        restart_dut(0, -1, 1'b0);
        wait_ready(seen);
        if (seen) begin
            @(posedge clk);
            log_clear <= 1'b1;
            @(posedge clk);
            log_clear <= 1'b0;
            hdmi_int  <= 1'b0;
            @(posedge clk);
            hdmi_int <= 1'b1;
            @(negedge clk);
            check_flag("ready after interrupt", ready, 1'b0);
            wait_ready(seen);
        end
        if (!seen) begin
            $display("hot-plug: ready did not rise within %0d cycles", test_budget);
            errors++;
        end else begin
            // ready has to hold after the second pass too
            repeat (4) @(negedge clk);
            check_log(1, -1);
            check_flag("ready", ready, 1'b1);
            check_count("pll_error_count", pll_error_count, '0);
        end
        report_test("hot-plug", start_errors);
    endtask

    initial begin
        reset          = 1'b0;
        hdmi_int       = 1'b1;
        log_clear      = 1'b0;
        pll_fail_reads = 0;
        nack_at        = -1;
        stretch_en     = 1'b0;
        power_up_test();
        pll_retry_test();
        nack_retry_test();
        hot_plug_test();
        stretch_test();
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (num_tests * test_budget) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", num_tests * test_budget);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/hdmi_tx_pkg.sv
src/adv7513_init_rom.sv
src/i2c_master.sv
src/adv7513_config_fsm.sv
src/adv7513_ctrl.sv
tb/adv7513_i2c_model.sv
tb/adv7513_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= adv7513_ctrl_tb
RTL_TOP   ?= adv7513_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
